//--- src/ls_config.svh
`ifndef LS_CONFIG_SVH
`define LS_CONFIG_SVH

// core data width and core address width
`define LS_XLEN 64

// axi side widths
`define LS_AXI_ADDR_W 32
`define LS_AXI_ID_W 4

// memory depth in 64-bit words (2 KiB from address zero)
`define LS_MEM_WORDS 256

`endif

//--- src/axi_pkg.sv
`include "ls_config.svh"

package axi_pkg;

    // write address layout shared with the read address
    typedef struct packed {
        logic [`LS_AXI_ADDR_W-1:0] addr;
        logic [2:0]                prot;
        logic [`LS_AXI_ID_W-1:0]   id;
        logic [7:0]                len;     // beats minus one
        logic [2:0]                size;
        logic [1:0]                burst;
        logic                      lock;
        logic [3:0]                cache;
        logic [3:0]                qos;
        logic [3:0]                region;
    } axi_aw_t;

    typedef axi_aw_t axi_ar_t;

    typedef struct packed {
        logic [`LS_XLEN-1:0]   data;
        logic [`LS_XLEN/8-1:0] strb;
        logic                  last;
    } axi_w_t;

    typedef struct packed {
        logic [1:0]              resp;
        logic [`LS_AXI_ID_W-1:0] id;
    } axi_b_t;

    typedef struct packed {
        logic [`LS_XLEN-1:0]     data;
        logic [1:0]              resp;
        logic                    last;
        logic [`LS_AXI_ID_W-1:0] id;
    } axi_r_t;

    localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;
    localparam logic [1:0] AXI_BURST_INCR  = 2'b01;
    localparam logic [2:0] AXI_PROT_DATA   = 3'b000;  // unprivileged, secure, data
    localparam logic [3:0] AXI_CACHE_NONCACHE = 4'b0000;
    localparam logic [3:0] AXI_CACHE_WB_ALLOC = 4'b1111;
    localparam logic [`LS_AXI_ID_W-1:0] AXI_BRIDGE_ID = 'd1;

endpackage

//--- src/ls_pkg.sv
`include "ls_config.svh"

package ls_pkg;

    // held store request from the core
    typedef struct packed {
        logic [`LS_XLEN-1:0]   addr;
        logic [`LS_XLEN-1:0]   data;
        logic [`LS_XLEN/8-1:0] mask;    // one bit per byte lane
    } ls_wr_req_t;

    // load result back to the core
    typedef struct packed {
        logic [`LS_XLEN-1:0] data;
        logic                err;
    } ls_rd_rsp_t;

endpackage

//--- src/axi_reg_slice.sv
`timescale 1ns/100ps

module axi_reg_slice #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     s_valid_i,
    output logic     s_ready_o,
    input  payload_t s_data_i,
    output logic     m_valid_o,
    input  logic     m_ready_i,
    output payload_t m_data_o
);

    logic     full;
    payload_t data_q;

    // take a new item when empty or when the old one leaves
    assign s_ready_o = ~full | m_ready_i;
    assign m_valid_o = full;
    assign m_data_o  = data_q;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            full <= 1'b0;
        end else if (s_ready_o) begin
            full <= s_valid_i;
        end
    end

    always_ff @(posedge clock) begin
        if (s_valid_i && s_ready_o) begin
            data_q <= s_data_i;
        end
    end

endmodule

//--- src/axi_ls_bridge.sv
`timescale 1ns/100ps
`include "ls_config.svh"

module axi_ls_bridge
    import axi_pkg::*;
    import ls_pkg::*;
(
    input  logic                clock,
    input  logic                reset,
    // core store side
    input  logic                wr_valid_i,
    input  ls_wr_req_t          wr_req_i,
    output logic                wr_ok_o,
    output logic                wr_err_o,
    // core load side
    input  logic                rd_valid_i,
    input  logic [`LS_XLEN-1:0] rd_addr_i,
    output logic                rd_ready_o,
    output ls_rd_rsp_t          rd_rsp_o,
    // axi master
    output logic                aw_valid_o,
    input  logic                aw_ready_i,
    output axi_aw_t             aw_o,
    output logic                w_valid_o,
    input  logic                w_ready_i,
    output axi_w_t              w_o,
    input  logic                b_valid_i,
    output logic                b_ready_o,
    input  axi_b_t              b_i,
    output logic                ar_valid_o,
    input  logic                ar_ready_i,
    output axi_ar_t             ar_o,
    input  logic                r_valid_i,
    output logic                r_ready_o,
    input  axi_r_t              r_i
);

    localparam logic [2:0] AXI_SIZE_FULL = 3'($clog2(`LS_XLEN / 8));

    typedef enum logic [1:0] {w_idle, w_aw_wait, w_w_wait, w_b_wait} wr_state_t;
    typedef enum logic [1:0] {r_idle, r_ar_wait, r_r_wait, r_done} rd_state_t;

    wr_state_t           w_state;
    wr_state_t           w_next;
    ls_wr_req_t          wr_req_q;      // request in flight
    logic                wr_done;       // b seen for this request
    logic                wr_err_q;
    logic                wr_issue;
    logic                wr_addr_hit;
    logic                b_fire;

    rd_state_t           r_state;
    rd_state_t           r_next;
    logic [`LS_XLEN-1:0] rd_addr_q;
    logic [`LS_XLEN-1:0] rd_data_q;
    logic                rd_err_q;
    logic                rd_issue;
    logic                rd_addr_hit;
    logic                r_fire;

    assign wr_addr_hit = (wr_req_i.addr == wr_req_q.addr);
    assign rd_addr_hit = (rd_addr_i == rd_addr_q);
    assign b_fire      = b_valid_i & b_ready_o;
    assign r_fire      = r_valid_i & r_ready_o;

    // write side issues aw then w and waits for b
    always_comb begin
        w_next   = w_state;
        wr_issue = 1'b0;
        case (w_state)
            w_idle: begin
                if (wr_valid_i) begin
                    w_next   = w_aw_wait;
                    wr_issue = 1'b1;
                end
            end
            w_aw_wait: if (aw_ready_i) w_next = w_w_wait;
            w_w_wait:  if (w_ready_i) w_next = w_b_wait;
            w_b_wait: begin
                if (wr_done && !wr_valid_i) begin
                    w_next = w_idle;
                end else if (wr_done && !wr_addr_hit) begin
                    w_next   = w_aw_wait;     // new address while held
                    wr_issue = 1'b1;
                end
            end
            default: w_next = w_idle;
        endcase
    end

    always_comb begin
        r_next   = r_state;
        rd_issue = 1'b0;
        case (r_state)
            r_idle: begin
                if (rd_valid_i) begin
                    r_next   = r_ar_wait;
                    rd_issue = 1'b1;
                end
            end
            r_ar_wait: if (ar_ready_i) r_next = r_r_wait;
            r_r_wait:  if (r_fire) r_next = r_done;
            r_done: begin
                if (!rd_valid_i) begin
                    r_next = r_idle;
                end else if (!rd_addr_hit) begin
                    r_next   = r_ar_wait;
                    rd_issue = 1'b1;
                end
            end
            default: r_next = r_idle;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            w_state <= w_idle;
            r_state <= r_idle;
            wr_done <= 1'b0;
        end else begin
            w_state <= w_next;
            r_state <= r_next;
            if (w_next != w_b_wait) begin
                wr_done <= 1'b0;
            end else if (b_fire) begin
                wr_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (wr_issue) wr_req_q <= wr_req_i;
        if (b_fire) wr_err_q <= (b_i.resp != AXI_RESP_OKAY);
        if (rd_issue) rd_addr_q <= rd_addr_i;
        if (r_fire) begin
            rd_data_q <= r_i.data;
            rd_err_q  <= (r_i.resp != AXI_RESP_OKAY);
        end
    end

    // single beat, full width, fixed id
    always_comb begin
        aw_o       = '0;
        aw_o.addr  = wr_req_q.addr[`LS_AXI_ADDR_W-1:0];
        aw_o.prot  = AXI_PROT_DATA;
        aw_o.id    = AXI_BRIDGE_ID;
        aw_o.size  = AXI_SIZE_FULL;
        aw_o.burst = AXI_BURST_INCR;
        aw_o.cache = AXI_CACHE_WB_ALLOC;
        ar_o       = aw_o;
        ar_o.addr  = rd_addr_q[`LS_AXI_ADDR_W-1:0];
        ar_o.cache = AXI_CACHE_NONCACHE;
        w_o.data   = wr_req_q.data;
        w_o.strb   = wr_req_q.mask;
        w_o.last   = 1'b1;
    end

    assign aw_valid_o = (w_state == w_aw_wait);
    assign w_valid_o  = (w_state == w_w_wait);
    assign b_ready_o  = (w_state == w_b_wait) & ~wr_done & b_valid_i;
    assign ar_valid_o = (r_state == r_ar_wait);
    assign r_ready_o  = (r_state == r_r_wait) & r_valid_i;

    // completion only while the same address is held
    assign wr_ok_o    = (w_state == w_b_wait) & wr_done & wr_valid_i & wr_addr_hit;
    assign wr_err_o   = wr_ok_o & wr_err_q;
    assign rd_ready_o = (r_state == r_done) & rd_valid_i & rd_addr_hit;
    assign rd_rsp_o   = rd_ready_o ? ls_rd_rsp_t'{data: rd_data_q, err: rd_err_q} : '0;

endmodule

//--- src/axi_sram.sv
`timescale 1ns/100ps
`include "ls_config.svh"

module axi_sram
    import axi_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  logic    aw_valid_i,
    output logic    aw_ready_o,
    input  axi_aw_t aw_i,
    input  logic    w_valid_i,
    output logic    w_ready_o,
    input  axi_w_t  w_i,
    output logic    b_valid_o,
    input  logic    b_ready_i,
    output axi_b_t  b_o,
    input  logic    ar_valid_i,
    output logic    ar_ready_o,
    input  axi_ar_t ar_i,
    output logic    r_valid_o,
    input  logic    r_ready_i,
    output axi_r_t  r_o
);

    localparam int OFF_W  = $clog2(`LS_XLEN / 8);
    localparam int IDX_W  = $clog2(`LS_MEM_WORDS);
    localparam int STRB_W = `LS_XLEN / 8;

    logic [`LS_XLEN-1:0] mem [`LS_MEM_WORDS];

    axi_aw_t          aw_q;
    axi_w_t           w_q;
    logic             aw_full;
    logic             w_full;
    logic             wr_go;        // address and data both here
    logic             aw_in_range;
    logic             ar_in_range;
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;

    assign aw_ready_o  = ~aw_full;
    assign w_ready_o   = ~w_full;
    assign ar_ready_o  = ~r_valid_o;    // one read outstanding
    assign wr_go       = aw_full & w_full & ~b_valid_o;

    assign aw_in_range = (aw_q.addr >> (OFF_W + IDX_W)) == '0;
    assign ar_in_range = (ar_i.addr >> (OFF_W + IDX_W)) == '0;
    assign wr_idx      = aw_q.addr[OFF_W +: IDX_W];
    assign rd_idx      = ar_i.addr[OFF_W +: IDX_W];

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            aw_full   <= 1'b0;
            w_full    <= 1'b0;
            b_valid_o <= 1'b0;
            r_valid_o <= 1'b0;
        end else begin
            if (aw_valid_i && aw_ready_o) aw_full <= 1'b1;
            else if (wr_go) aw_full <= 1'b0;
            if (w_valid_i && w_ready_o) w_full <= 1'b1;
            else if (wr_go) w_full <= 1'b0;
            if (wr_go) b_valid_o <= 1'b1;
            else if (b_ready_i) b_valid_o <= 1'b0;
            if (ar_valid_i && ar_ready_o) r_valid_o <= 1'b1;
            else if (r_ready_i) r_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (aw_valid_i && aw_ready_o) aw_q <= aw_i;
        if (w_valid_i && w_ready_o) w_q <= w_i;
        if (wr_go) begin
            b_o.resp <= aw_in_range ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
            b_o.id   <= aw_q.id;
        end
        if (ar_valid_i && ar_ready_o) begin
            r_o.data <= ar_in_range ? mem[rd_idx] : '0;
            r_o.resp <= ar_in_range ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
            r_o.last <= 1'b1;
            r_o.id   <= ar_i.id;
        end
    end

    // byte lanes under the strobe only
    always_ff @(posedge clock) begin
        if (wr_go && aw_in_range) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (w_q.strb[i]) mem[wr_idx][i*8 +: 8] <= w_q.data[i*8 +: 8];
            end
        end
    end

endmodule

//--- src/ls_mem_top.sv
`timescale 1ns/100ps
`include "ls_config.svh"

module ls_mem_top
    import axi_pkg::*;
    import ls_pkg::*;
(
    input  logic                clock,
    input  logic                reset,
    input  logic                wr_valid_i,
    input  ls_wr_req_t          wr_req_i,
    output logic                wr_ok_o,
    output logic                wr_err_o,
    input  logic                rd_valid_i,
    input  logic [`LS_XLEN-1:0] rd_addr_i,
    output logic                rd_ready_o,
    output ls_rd_rsp_t          rd_rsp_o
);

    // bridge side of the slices
    logic    aw_valid_b, aw_ready_b, w_valid_b, w_ready_b, ar_valid_b, ar_ready_b;
    axi_aw_t aw_b;
    axi_w_t  w_b;
    axi_ar_t ar_b;
    // memory side of the slices
    logic    aw_valid_m, aw_ready_m, w_valid_m, w_ready_m, ar_valid_m, ar_ready_m;
    axi_aw_t aw_m;
    axi_w_t  w_m;
    axi_ar_t ar_m;
    // responses go straight back
    logic    b_valid, b_ready, r_valid, r_ready;
    axi_b_t  b_rsp;
    axi_r_t  r_rsp;

    axi_ls_bridge u_bridge (
        .clock, .reset,
        .wr_valid_i, .wr_req_i, .wr_ok_o, .wr_err_o,
        .rd_valid_i, .rd_addr_i, .rd_ready_o, .rd_rsp_o,
        .aw_valid_o(aw_valid_b), .aw_ready_i(aw_ready_b), .aw_o(aw_b),
        .w_valid_o(w_valid_b), .w_ready_i(w_ready_b), .w_o(w_b),
        .b_valid_i(b_valid), .b_ready_o(b_ready), .b_i(b_rsp),
        .ar_valid_o(ar_valid_b), .ar_ready_i(ar_ready_b), .ar_o(ar_b),
        .r_valid_i(r_valid), .r_ready_o(r_ready), .r_i(r_rsp)
    );

    axi_reg_slice #(.payload_t(axi_aw_t)) u_aw_slice (
        .clock, .reset,
        .s_valid_i(aw_valid_b), .s_ready_o(aw_ready_b), .s_data_i(aw_b),
        .m_valid_o(aw_valid_m), .m_ready_i(aw_ready_m), .m_data_o(aw_m)
    );

    axi_reg_slice #(.payload_t(axi_w_t)) u_w_slice (
        .clock, .reset,
        .s_valid_i(w_valid_b), .s_ready_o(w_ready_b), .s_data_i(w_b),
        .m_valid_o(w_valid_m), .m_ready_i(w_ready_m), .m_data_o(w_m)
    );

    axi_reg_slice #(.payload_t(axi_ar_t)) u_ar_slice (
        .clock, .reset,
        .s_valid_i(ar_valid_b), .s_ready_o(ar_ready_b), .s_data_i(ar_b),
        .m_valid_o(ar_valid_m), .m_ready_i(ar_ready_m), .m_data_o(ar_m)
    );

    axi_sram u_sram (
        .clock, .reset,
        .aw_valid_i(aw_valid_m), .aw_ready_o(aw_ready_m), .aw_i(aw_m),
        .w_valid_i(w_valid_m), .w_ready_o(w_ready_m), .w_i(w_m),
        .b_valid_o(b_valid), .b_ready_i(b_ready), .b_o(b_rsp),
        .ar_valid_i(ar_valid_m), .ar_ready_o(ar_ready_m), .ar_i(ar_m),
        .r_valid_o(r_valid), .r_ready_i(r_ready), .r_o(r_rsp)
    );

endmodule

//--- bench/tb_ls_mem.sv
`timescale 1ns/100ps
`include "ls_config.svh"

module tb_ls_mem import ls_pkg::*; ();

    localparam int          N_OPS      = 58;   // reads and writes over all tests
    localparam int          MAX_CYCLES = 40 * N_OPS + 100;
    localparam int          IDX_W      = $clog2(`LS_MEM_WORDS);
    localparam logic [63:0] MEM_BYTES  = 64'(`LS_MEM_WORDS * 8);

    logic                clock;
    logic                reset;
    logic                wr_valid_i;
    ls_wr_req_t          wr_req_i;
    logic                wr_ok_o;
    logic                wr_err_o;
    logic                rd_valid_i;
    logic [`LS_XLEN-1:0] rd_addr_i;
    logic                rd_ready_o;
    ls_rd_rsp_t          rd_rsp_o;

    logic [`LS_XLEN-1:0] ref_mem [`LS_MEM_WORDS];  // reference model of the memory
    integer              seed;
    int                  errors = 0;
    int                  test_errors = 0;
    int                  tests_run = 0;
    int                  cycles = 0;

    ls_mem_top u_dut (
        .clock, .reset,
        .wr_valid_i, .wr_req_i, .wr_ok_o, .wr_err_o,
        .rd_valid_i, .rd_addr_i, .rd_ready_o, .rd_rsp_o
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: no completion seen within %0d clock cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
        if (got !== exp) begin
            $display("error t=%0t %s expected %h got %h", $time, name, exp, got);
            errors++;
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("%s done, %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    function automatic logic [63:0] merge_bytes(input logic [63:0] old_w,
                                                input logic [63:0] new_w,
                                                input logic [7:0] mask);
        logic [63:0] res;
        res = old_w;
        for (int i = 0; i < 8; i++) begin
            if (mask[i]) res[i*8 +: 8] = new_w[i*8 +: 8];
        end
        return res;
    endfunction

    function automatic logic in_range(input logic [63:0] addr);
        return addr < MEM_BYTES;
    endfunction

    function automatic logic [63:0] rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic write_word(input logic [63:0] addr, input logic [63:0] data,
                              input logic [7:0] mask);
        logic             exp_err;
        logic [IDX_W-1:0] idx;
        exp_err = !in_range(addr);
        idx     = addr[3 +: IDX_W];
        @(negedge clock);
        wr_req_i   = '{addr: addr, data: data, mask: mask};
        wr_valid_i = 1'b1;
        @(negedge clock);
        while (!wr_ok_o) @(negedge clock);
        check_val("wr_err_o", 64'(exp_err), 64'(wr_err_o));
        if (!exp_err) ref_mem[idx] = merge_bytes(ref_mem[idx], data, mask);
        wr_valid_i = 1'b0;    // back to idle before the next request
    endtask

    task automatic wait_read();
        @(negedge clock);
        while (!rd_ready_o) @(negedge clock);
    endtask

    // expected response comes from the reference model
    task automatic check_read_rsp(input logic [63:0] addr);
        logic        exp_err;
        logic [63:0] exp_data;
        exp_err  = !in_range(addr);
        exp_data = exp_err ? 64'd0 : ref_mem[addr[3 +: IDX_W]];
        check_val("rd_rsp_o.data", exp_data, rd_rsp_o.data);
        check_val("rd_rsp_o.err", 64'(exp_err), 64'(rd_rsp_o.err));
    endtask

    task automatic read_word(input logic [63:0] addr);
        @(negedge clock);
        rd_addr_i  = addr;
        rd_valid_i = 1'b1;
        wait_read();
        check_read_rsp(addr);
        rd_valid_i = 1'b0;
    endtask

    task automatic test_reset();
        check_val("wr_ok_o", 64'd0, 64'(wr_ok_o));
        check_val("rd_ready_o", 64'd0, 64'(rd_ready_o));
        check_val("rd_rsp_o.data", 64'd0, rd_rsp_o.data);
        end_test("reset");
    endtask

    task automatic test_full_word();
        write_word(64'h40, rand_word(), 8'hff);
        read_word(64'h40);
        end_test("full_word");
    endtask

    task automatic test_partial_mask();
        write_word(64'h88, rand_word(), 8'hff);
        write_word(64'h88, rand_word(), 8'h5a);   // only lanes 1, 3, 4, 6
        read_word(64'h88);
        end_test("partial_mask");
    endtask

    task automatic test_addr_switch();
        write_word(64'h100, rand_word(), 8'hff);
        write_word(64'h1f8, rand_word(), 8'hff);
        @(negedge clock);
        rd_addr_i  = 64'h100;
        rd_valid_i = 1'b1;
        wait_read();
        check_read_rsp(64'h100);
        rd_addr_i = 64'h1f8;    // request stays held
        #1;
        check_val("rd_ready_o", 64'd0, 64'(rd_ready_o));
        wait_read();
        check_read_rsp(64'h1f8);
        rd_valid_i = 1'b0;
        end_test("addr_switch");
    endtask

    task automatic test_out_of_range();
        write_word(MEM_BYTES + 64'h40, rand_word(), 8'hff);  // would alias word 8
        read_word(MEM_BYTES + 64'h88);   // would alias word 17
        read_word(64'h40);
        end_test("out_of_range");
    endtask

    task automatic test_random();
        logic [3:0]  idx;
        logic [63:0] addr;
        // fill every word first so each read has an expected value
        for (int i = 0; i < 16; i++) write_word(64'(i) << 3, rand_word(), 8'hff);
        for (int n = 0; n < 30; n++) begin
            idx  = 4'($random(seed));
            addr = 64'(idx) << 3;
            if ($random(seed) & 1) write_word(addr, rand_word(), 8'($random(seed)));
            else read_word(addr);
        end
        end_test("random");
    endtask

    initial begin
        seed       = 32'h71f6_253f;
        reset      = 1'b0;
        wr_valid_i = 1'b0;
        wr_req_i   = '0;
        rd_valid_i = 1'b0;
        rd_addr_i  = '0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        test_reset();
        test_full_word();
        test_partial_mask();
        test_addr_switch();
        test_out_of_range();
        test_random();
        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+src
src/axi_pkg.sv
src/ls_pkg.sv
src/axi_reg_slice.sv
src/axi_ls_bridge.sv
src/axi_sram.sv
src/ls_mem_top.sv
bench/tb_ls_mem.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f tb.f --top-module tb_ls_mem -o sim_ls_mem
./obj_dir/sim_ls_mem > sim.log
cat sim.log

if grep -q "PASS: all tests" sim.log; then
    exit 0
fi
exit 1
